/* src/ctrlPkg.sv */
package ctrlPkg;

  // ====================
  // Instruction fields
  // ====================
  localparam int condHi        = 31;
  localparam int condLo        = 28;
  localparam int classHi       = 27;
  localparam int classLo       = 26;
  localparam int immBit        = 25;  // I bit, operand 2 form
  localparam int preIndexUpBit = 23;  // U bit, add or subtract offset
  localparam int byteBit       = 22;  // B bit on single transfers
  localparam int sBit          = 20;  // Set flags
  localparam int loadBit       = 20;  // L bit, shares position with S
  localparam int rdHi          = 15;
  localparam int rdLo          = 12;

  localparam logic [3:0]  pcReg     = 4'd15;
  localparam logic [3:0]  opAdd     = 4'b0100;
  localparam logic [3:0]  opSub     = 4'b0010;
  localparam logic [3:0]  opMov     = 4'b1101;
  localparam logic [23:0] bxPattern = 24'h12FFF1;  // Bits 27..4 of BX
  localparam logic [3:0]  wordMask  = 4'b1111;

  // ====================
  // Control types
  // ====================
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef enum logic [3:0] {
    condEQ, condNE, condCS, condCC, condMI, condPL, condVS, condVC,
    condHI, condLS, condGE, condLT, condGT, condLE, condAL, condNV
  } condT;

  typedef struct packed {
    logic [1:0] regSrc;  // Bit 0 reads PC, bit 1 reads Rd for stores
    logic [1:0] immSrc;  // Extend type for the immediate
  } srcSelT;

  typedef struct packed {
    logic       aluSrc;
    logic       memtoReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       pcWrite;
    logic       bx;
    logic       byteAccess;
    logic       loadStore;
    logic       flagWrite;
    logic [3:0] aluControl;
    condT       cond;
  } decCtrlT;

  typedef struct packed {
    logic       aluSrc;
    logic [3:0] aluControl;
  } exCtrlT;

  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic       pcWrite;
    logic       byteLoad;
    logic [3:0] byteMask;
    logic [1:0] byteOffset;  // Lane of a byte load
  } memCtrlT;

  typedef struct packed {
    logic       memtoReg;
    logic       regWrite;
    logic       pcWrite;
    logic       byteLoad;
    logic [1:0] byteOffset;
  } wbCtrlT;

endpackage

/* src/mainDecoder.sv */
module mainDecoder (
  input  logic [31:0]      instrD,
  output ctrlPkg::decCtrlT ctrlD,
  output ctrlPkg::srcSelT  srcSelD
);
  import ctrlPkg::*;

  logic [1:0] instrClass;
  logic       isBx;
  logic       isExtraSpace;  // Multiply and halfword encodings
  logic       isCompare;
  logic       rdIsPc;
  logic       validD;        // Instruction falls in a supported class

  assign instrClass   = instrD[classHi:classLo];
  assign isBx         = (instrD[classHi:4] == bxPattern);
  assign isExtraSpace = ~instrD[immBit] & instrD[7] & instrD[4];
  assign isCompare    = (instrD[24:23] == 2'b10);  // TST TEQ CMP CMN
  assign rdIsPc       = (instrD[rdHi:rdLo] == pcReg);

  always_comb begin
    ctrlD   = '0;  // Undefined gives all-zero control
    srcSelD = '0;
    validD  = 1'b0;
    case (instrClass)
      // ==================
      // Data processing
      // ==================
      2'b00: begin
        if (isBx) begin
          validD           = 1'b1;
          ctrlD.bx         = 1'b1;
          ctrlD.aluControl = opMov;  // Pass Rm through as target
        end else if (!isExtraSpace) begin
          validD           = 1'b1;
          ctrlD.aluSrc     = instrD[immBit];  // Rotated imm8 or Rm
          ctrlD.regWrite   = ~isCompare;      // Compares only set flags
          ctrlD.aluControl = instrD[24:21];
          ctrlD.flagWrite  = instrD[sBit];
        end
      end
      // ==================
      // Single transfer
      // ==================
      2'b01: begin
        // I bit set means register offset here, bit 4 set is undefined
        if (!(instrD[immBit] && instrD[4])) begin
          validD           = 1'b1;
          ctrlD.loadStore  = 1'b1;
          ctrlD.aluSrc     = ~instrD[immBit];  // imm12 offset
          ctrlD.byteAccess = instrD[byteBit];
          ctrlD.aluControl = instrD[preIndexUpBit] ? opAdd : opSub;
          srcSelD.immSrc   = 2'b01;
          if (instrD[loadBit]) begin
            ctrlD.memtoReg = 1'b1;
            ctrlD.regWrite = 1'b1;
          end else begin
            ctrlD.memWrite = 1'b1;
            srcSelD.regSrc = 2'b10;  // Store data from Rd
          end
        end
      end
      2'b10: begin
        validD           = 1'b1;
        ctrlD.branch     = 1'b1;
        ctrlD.aluSrc     = 1'b1;
        ctrlD.aluControl = opAdd;  // PC plus offset
        srcSelD.regSrc   = 2'b01;
        srcSelD.immSrc   = 2'b10;  // imm24 shifted by 2
      end
      default: ;  // Coprocessor and SWI space
    endcase

    // Any path to the PC
    ctrlD.pcWrite = ctrlD.branch | ctrlD.bx | (ctrlD.regWrite & rdIsPc);
    if (validD) begin
      ctrlD.cond = condT'(instrD[condHi:condLo]);
    end
  end

endmodule

/* src/condCheck.sv */
module condCheck (
  input  ctrlPkg::condT  cond,
  input  ctrlPkg::flagsT flags,
  input  ctrlPkg::flagsT aluFlags,
  input  logic           flagWrite,
  output logic           condEx,
  output ctrlPkg::flagsT flagsNext
);
  import ctrlPkg::*;

  logic signedGe;  // N equals V

  assign signedGe = (flags.n == flags.v);

  always_comb begin
    case (cond)
      condEQ:  condEx = flags.z;
      condNE:  condEx = ~flags.z;
      condCS:  condEx = flags.c;
      condCC:  condEx = ~flags.c;
      condMI:  condEx = flags.n;
      condPL:  condEx = ~flags.n;
      condVS:  condEx = flags.v;
      condVC:  condEx = ~flags.v;
      // Unsigned higher / lower or same
      condHI:  condEx = flags.c & ~flags.z;
      condLS:  condEx = ~flags.c | flags.z;
      // Signed comparisons
      condGE:  condEx = signedGe;
      condLT:  condEx = ~signedGe;
      condGT:  condEx = ~flags.z & signedGe;
      condLE:  condEx = flags.z | ~signedGe;
      condAL:  condEx = 1'b1;
      default: condEx = 1'b0;  // NV never executes
    endcase
  end

  // Only a passing flag-setting instruction updates NZCV
  assign flagsNext = (flagWrite && condEx) ? aluFlags : flags;

endmodule

/* src/byteLaneMask.sv */
module byteLaneMask (
  input  logic       byteAccess,
  input  logic [1:0] addrLow,
  output logic [3:0] byteMask
);
  import ctrlPkg::*;

  logic [3:0] laneSel;  // One-hot lane, lane 0 at bit 0

  always_comb begin
    case (addrLow)
      2'd0:    laneSel = 4'b0001;
      2'd1:    laneSel = 4'b0010;
      2'd2:    laneSel = 4'b0100;
      default: laneSel = 4'b1000;
    endcase
  end

  // Words enable every lane
  assign byteMask = byteAccess ? laneSel : wordMask;

endmodule

/* src/executeStage.sv */
module executeStage (
  input  logic             clk,
  input  logic             rst,
  input  logic             stallE,
  input  logic             flushE,
  input  ctrlPkg::decCtrlT ctrlD,
  input  ctrlPkg::flagsT   flagsFwd,   // Newest in-flight NZCV
  input  ctrlPkg::flagsT   aluFlagsE,
  input  logic [1:0]       addrLowE,   // ALU result bits 1..0
  output ctrlPkg::exCtrlT  exCtrlE,
  output logic             branchTakenE,
  output logic             pcWriteE,
  output ctrlPkg::flagsT   flagsE,
  output ctrlPkg::memCtrlT memCtrlE,
  output logic             flagWriteE,
  output ctrlPkg::flagsT   flagsNextE
);
  import ctrlPkg::*;

  decCtrlT    ctrlE;
  logic       condExE;
  logic [3:0] byteMaskE;

  // ====================
  // Execute register
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlE <= '0;
    end else if (!stallE) begin
      if (flushE) begin
        ctrlE <= '0;  // Bubble
      end else begin
        ctrlE <= ctrlD;
      end
    end
  end

  // Datapath operand control
  always_comb begin
    exCtrlE.aluSrc     = ctrlE.aluSrc;
    exCtrlE.aluControl = ctrlE.aluControl;
  end

  condCheck cond_i (
    .cond      (ctrlE.cond),
    .flags     (flagsFwd),
    .aluFlags  (aluFlagsE),
    .flagWrite (ctrlE.flagWrite),
    .condEx    (condExE),
    .flagsNext (flagsNextE)
  );

  byteLaneMask mask_i (
    .byteAccess (ctrlE.byteAccess),
    .addrLow    (addrLowE),
    .byteMask   (byteMaskE)
  );

  assign flagsE       = flagsFwd;
  assign pcWriteE     = ctrlE.pcWrite;  // Ungated, for fetch hazard tracking
  assign branchTakenE = (ctrlE.branch | ctrlE.bx) & condExE;
  assign flagWriteE   = ctrlE.flagWrite & condExE;

  // ====================
  // Memory-bound control
  // ====================
  always_comb begin
    memCtrlE.memWrite   = ctrlE.memWrite & condExE;
    memCtrlE.memtoReg   = ctrlE.memtoReg;
    memCtrlE.regWrite   = ctrlE.regWrite & condExE;
    memCtrlE.pcWrite    = ctrlE.pcWrite & condExE;
    // LDRB picks one lane out of the read word
    memCtrlE.byteLoad   = ctrlE.loadStore & ctrlE.byteAccess & ctrlE.memtoReg;
    memCtrlE.byteMask   = byteMaskE;
    memCtrlE.byteOffset = addrLowE;
  end

endmodule

/* src/retireStage.sv */
module retireStage (
  input  logic             clk,
  input  logic             rst,
  input  logic             stallM,
  input  logic             stallW,
  input  logic             flushW,
  input  ctrlPkg::memCtrlT memCtrlE,
  input  logic             flagWriteE,  // Already condition gated
  input  ctrlPkg::flagsT   flagsNextE,
  output ctrlPkg::memCtrlT memCtrlM,
  output ctrlPkg::wbCtrlT  wbCtrlW,
  output ctrlPkg::flagsT   flagsFwd,
  output ctrlPkg::flagsT   flagsReg
);
  import ctrlPkg::*;

  logic  flagWriteM;
  logic  flagWriteW;
  flagsT flagsM;
  flagsT flagsW;

  // ====================
  // Memory register
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      memCtrlM   <= '0;
      flagWriteM <= 1'b0;
    end else if (!stallM) begin  // No flush at Memory
      memCtrlM   <= memCtrlE;
      flagWriteM <= flagWriteE;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallM) flagsM <= flagsNextE;
  end

  // ====================
  // Writeback register
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      wbCtrlW    <= '0;
      flagWriteW <= 1'b0;
    end else if (!stallW) begin
      if (flushW) begin
        wbCtrlW    <= '0;
        flagWriteW <= 1'b0;
      end else begin
        wbCtrlW.memtoReg   <= memCtrlM.memtoReg;
        wbCtrlW.regWrite   <= memCtrlM.regWrite;
        wbCtrlW.pcWrite    <= memCtrlM.pcWrite;
        wbCtrlW.byteLoad   <= memCtrlM.byteLoad;
        wbCtrlW.byteOffset <= memCtrlM.byteOffset;
        flagWriteW         <= flagWriteM;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stallW) flagsW <= flagsM;
  end

  // Architectural NZCV, committed at Writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      flagsReg <= '0;
    end else if (flagWriteW && !stallW) begin
      flagsReg <= flagsW;
    end
  end

  // Youngest pending flag write wins
  assign flagsFwd = flagWriteM ? flagsM :
                    flagWriteW ? flagsW : flagsReg;

endmodule

/* src/armController.sv */
module armController (
  input  logic             clk,
  input  logic             rst,
  // Datapath
  input  logic [31:0]      instrD,
  input  ctrlPkg::flagsT   aluFlagsE,
  input  logic [1:0]       addrLowE,
  // Hazard unit
  input  logic             stallE,
  input  logic             flushE,
  input  logic             stallM,
  input  logic             stallW,
  input  logic             flushW,
  // Datapath control
  output ctrlPkg::srcSelT  srcSelD,
  output ctrlPkg::exCtrlT  exCtrlE,
  output ctrlPkg::flagsT   flagsE,
  output logic             branchTakenE,
  output ctrlPkg::memCtrlT memCtrlM,
  output ctrlPkg::wbCtrlT  wbCtrlW,
  output ctrlPkg::flagsT   flagsReg,
  output logic             pcWrPendingF  // To hazard unit, holds fetch
);
  import ctrlPkg::*;

  decCtrlT ctrlD;
  memCtrlT memCtrlE;
  flagsT   flagsFwd;
  flagsT   flagsNextE;
  logic    pcWriteE;
  logic    flagWriteE;

  mainDecoder decoder_i (
    .instrD  (instrD),
    .ctrlD   (ctrlD),
    .srcSelD (srcSelD)
  );

  executeStage execute_i (
    .clk          (clk),
    .rst          (rst),
    .stallE       (stallE),
    .flushE       (flushE),
    .ctrlD        (ctrlD),
    .flagsFwd     (flagsFwd),
    .aluFlagsE    (aluFlagsE),
    .addrLowE     (addrLowE),
    .exCtrlE      (exCtrlE),
    .branchTakenE (branchTakenE),
    .pcWriteE     (pcWriteE),
    .flagsE       (flagsE),
    .memCtrlE     (memCtrlE),
    .flagWriteE   (flagWriteE),
    .flagsNextE   (flagsNextE)
  );

  retireStage retire_i (
    .clk        (clk),
    .rst        (rst),
    .stallM     (stallM),
    .stallW     (stallW),
    .flushW     (flushW),
    .memCtrlE   (memCtrlE),
    .flagWriteE (flagWriteE),
    .flagsNextE (flagsNextE),
    .memCtrlM   (memCtrlM),
    .wbCtrlW    (wbCtrlW),
    .flagsFwd   (flagsFwd),
    .flagsReg   (flagsReg)
  );

  // PC write anywhere from Decode to Memory
  assign pcWrPendingF = ctrlD.pcWrite | pcWriteE | memCtrlM.pcWrite;

endmodule

/* testbench/armController_asserts.sv */
module armController_asserts (
  input logic             clk,
  input logic             rst,
  input logic             branchTakenE,
  input logic             pcWrPendingF,
  input ctrlPkg::memCtrlT memCtrlM,
  input ctrlPkg::wbCtrlT  wbCtrlW
);
  import ctrlPkg::*;

  // Taken branch is always a pending PC write
  branchPending: assert property (@(posedge clk) disable iff (rst)
    branchTakenE |-> pcWrPendingF)
    else $error("branchTakenE high without pcWrPendingF");

  // Registered strobes quiet right after reset
  resetQuiet: assert property (@(posedge clk)
    rst |=> !branchTakenE && !memCtrlM.regWrite && !memCtrlM.memWrite
            && !memCtrlM.pcWrite && !wbCtrlW.regWrite && !wbCtrlW.pcWrite)
    else $error("strobe active one cycle after reset");

  // Full word or a single lane
  maskShape: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> (memCtrlM.byteMask == wordMask || $onehot(memCtrlM.byteMask)))
    else $error("byteMask neither full word nor one-hot");

endmodule

bind armController armController_asserts asserts_i (
  .clk          (clk),
  .rst          (rst),
  .branchTakenE (branchTakenE),
  .pcWrPendingF (pcWrPendingF),
  .memCtrlM     (memCtrlM),
  .wbCtrlW      (wbCtrlW)
);

/* testbench/controllerTb.sv */
module controllerTb;
  import ctrlPkg::*;

  // Decoder strobes expected for one row
  typedef struct packed {
    logic regWrite;
    logic memWrite;
    logic memtoReg;
    logic pcWrite;
    logic branch;      // B or BX
    logic flagWrite;
    logic byteAccess;
  } strobeT;

  typedef struct packed {
    logic [31:0] instr;
    flagsT       aluFlags;  // Used while the row sits in Execute
    logic [1:0]  addrLow;
    logic        stall;
    logic        flush;
    logic        aluSrc;
    logic [3:0]  aluCtl;
    srcSelT      srcSel;    // Expected at Decode
    strobeT      strb;
  } rowT;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] instrD;
  flagsT       aluFlagsE;
  logic [1:0]  addrLowE;
  logic        stallE;
  logic        flushE;
  logic        stallM;
  logic        stallW;
  logic        flushW;
  srcSelT      srcSelD;
  exCtrlT      exCtrlE;
  flagsT       flagsE;
  logic        branchTakenE;
  memCtrlT     memCtrlM;
  wbCtrlT      wbCtrlW;
  flagsT       flagsReg;
  logic        pcWrPendingF;

  rowT   rows[$];
  string rowTest[$];
  logic  tableReady = 1'b0;
  int    checkCount = 0;
  int    errorCount = 0;

  armController dut_i (.*);

  always #10 clk = ~clk;

  task automatic checkEq(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic addRow(input string name, input logic [31:0] instr, input flagsT aluFlags,
                        input logic [1:0] addrLow, input logic [1:0] hazard,
                        input logic [4:0] exCtl, input srcSelT srcSel, input strobeT strb);
    rowT r;
    r.instr              = instr;
    r.aluFlags           = aluFlags;
    r.addrLow            = addrLow;
    {r.stall, r.flush}   = hazard;  // stallE, flushE
    {r.aluSrc, r.aluCtl} = exCtl;
    r.srcSel             = srcSel;
    r.strb               = strb;
    rows.push_back(r);
    rowTest.push_back(name);
  endtask

  // Base test picked by cond[3:1] and inverted for odd codes
  function automatic logic condHolds(input logic [3:0] c, input flagsT f);
    logic base;
    case (c[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c & ~f.z;          // HI
      3'd5:    base = (f.n == f.v);        // GE
      3'd6:    base = ~f.z & (f.n == f.v); // GT
      default: base = 1'b1;
    endcase
    if (c == 4'hF) return 1'b0;  // NV
    return base ^ (c[0] & (c[3:1] != 3'd7));
  endfunction

  // ====================
  // Stimulus and model
  // ====================
  initial begin
    rowT     cur;
    rowT     ex;          // Row held in Execute
    memCtrlT memE;
    memCtrlT memExp;
    wbCtrlT  wbExp;
    flagsT   fwdExp;
    flagsT   nextFlags;
    flagsT   flagsMExp;
    flagsT   flagsWExp;
    flagsT   flagsRegExp;
    logic    flagWrM;
    logic    flagWrW;
    logic    flagWrE;
    logic    condOk;
    int      groupStart;
    void'($urandom(41905));
    rst = 1'b1;
    instrD = '0;
    aluFlagsE = '0;
    addrLowE = '0;
    stallE = 1'b0;
    flushE = 1'b0;
    stallM = 1'b0;
    stallW = 1'b0;
    flushW = 1'b0;

    // name, instr, aluFlagsE, addrLowE, {stall,flush}, {aluSrc,aluCtl}, {regSrc,immSrc}
    // then rw mw m2r pcw br fw ba
    addRow("dataProc", 32'hE2821005, 4'h0, 2'd0, 2'b00, {1'b1, opAdd}, 4'h0, 7'b1000000);
    addRow("dataProc", 32'hE0443005, 4'h0, 2'd0, 2'b00, {1'b0, opSub}, 4'h0, 7'b1000000);
    addRow("dataProc", 32'hE1876008, 4'h0, 2'd0, 2'b00, {1'b0, 4'b1100}, 4'h0, 7'b1000000);
    addRow("dataProc", 32'hE3510000, 4'h4, 2'd0, 2'b00, {1'b1, 4'b1010}, 4'h0, 7'b0000010);
    addRow("flagSet", 32'hE0921003, 4'h9, 2'd0, 2'b00, {1'b0, opAdd}, 4'h0, 7'b1000010);
    addRow("flagSet", 32'hA3A04001, 4'h0, 2'd0, 2'b00, {1'b1, opMov}, 4'h0, 7'b1000000);
    addRow("flagSet", 32'h43A05002, 4'h0, 2'd0, 2'b00, {1'b1, opMov}, 4'h0, 7'b1000000);
    addRow("flagSet", 32'hE1A00000, 4'h0, 2'd0, 2'b00, {1'b0, opMov}, 4'h0, 7'b1000000);
    addRow("condFail", 32'h02811001, 4'h0, 2'd0, 2'b00, {1'b1, opAdd}, 4'h0, 7'b1000000);
    addRow("condFail", 32'h05821004, 4'h0, 2'd0, 2'b00, {1'b1, opAdd}, 4'h9, 7'b0100000);
    addRow("condFail", 32'h03510000, 4'h6, 2'd0, 2'b00, {1'b1, 4'b1010}, 4'h0, 7'b0000010);
    addRow("condFail", 32'h0A000010, 4'h0, 2'd0, 2'b00, {1'b1, opAdd}, 4'h6, 7'b0001100);
    addRow("condFail", 32'h1A000010, 4'h0, 2'd0, 2'b00, {1'b1, opAdd}, 4'h6, 7'b0001100);
    addRow("loadStore", 32'hE5921008, 4'h0, 2'd0, 2'b00, {1'b1, opAdd}, 4'h1, 7'b1010000);
    addRow("loadStore", 32'hE5443001, 4'h0, 2'd3, 2'b00, {1'b1, opSub}, 4'h9, 7'b0100001);
    addRow("loadStore", 32'hE7D65007, 4'h0, 2'd1, 2'b00, {1'b0, opAdd}, 4'h1, 7'b1010001);
    addRow("loadStore", 32'hE591F000, 4'h0, 2'd2, 2'b00, {1'b1, opAdd}, 4'h1, 7'b1011000);
    addRow("stallFlush", 32'hE2821005, 4'h0, 2'd0, 2'b00, {1'b1, opAdd}, 4'h0, 7'b1000000);
    addRow("stallFlush", 32'hE0443005, 4'h0, 2'd0, 2'b10, {1'b0, opSub}, 4'h0, 7'b1000000);
    addRow("stallFlush", 32'hE1876008, 4'h0, 2'd0, 2'b01, {1'b0, 4'b1100}, 4'h0, 7'b1000000);
    addRow("stallFlush", 32'hE1A00000, 4'h0, 2'd0, 2'b00, {1'b0, opMov}, 4'h0, 7'b1000000);
    addRow("pcWrite", 32'hE12FFF11, 4'h0, 2'd0, 2'b00, {1'b0, opMov}, 4'h0, 7'b0001100);
    addRow("pcWrite", 32'hE1A0F00E, 4'h0, 2'd0, 2'b00, {1'b0, opMov}, 4'h0, 7'b1001000);
    addRow("pcWrite", 32'hEA000004, 4'h0, 2'd0, 2'b00, {1'b1, opAdd}, 4'h6, 7'b0001100);
    addRow("undefined", 32'hE0000291, 4'h0, 2'd0, 2'b00, 5'h00, 4'h0, 7'b0000000);  // MUL
    addRow("undefined", 32'hEF000000, 4'h0, 2'd0, 2'b00, 5'h00, 4'h0, 7'b0000000);  // SWI
    for (int c = 0; c < 15; c++) begin
      addRow("condRandom", 32'hE0921003, 4'($urandom), 2'($urandom), 2'b00,
             {1'b0, opAdd}, 4'h0, 7'b1000010);  // ADDS with random NZCV
      addRow("condRandom", {4'(c), 28'h3A04001}, 4'h0, 2'($urandom), 2'b00,
             {1'b1, opMov}, 4'h0, 7'b1000000);  // MOV under each condition
    end
    for (int i = 0; i < 4; i++) begin
      addRow("byteRandom", 32'hE5D65002, 4'h0, 2'($urandom), 2'b00,
             {1'b1, opAdd}, 4'h1, 7'b1010001);  // LDRB at a random lane
    end
    repeat (4) addRow("drain", 32'hE1A00000, 4'h0, 2'd0, 2'b00, {1'b0, opMov}, 4'h0,
                      7'b1000000);
    tableReady = 1'b1;

    ex = '0;
    memExp = '0;
    wbExp = '0;
    flagsMExp = '0;
    flagsWExp = '0;
    flagsRegExp = '0;
    flagWrM = 1'b0;
    flagWrW = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    groupStart = 0;

    for (int k = 0; k < rows.size(); k++) begin
      cur       = rows[k];
      instrD    = cur.instr;
      stallE    = cur.stall;
      flushE    = cur.flush;
      aluFlagsE = ex.aluFlags;  // Belongs to the row in Execute
      addrLowE  = ex.addrLow;
      #5;  // Mid low phase with outputs settled

      // Newest in-flight flags first
      fwdExp    = flagWrM ? flagsMExp : (flagWrW ? flagsWExp : flagsRegExp);
      condOk    = condHolds(ex.instr[31:28], fwdExp);
      flagWrE   = ex.strb.flagWrite & condOk;
      nextFlags = flagWrE ? ex.aluFlags : fwdExp;
      memE.memWrite   = ex.strb.memWrite & condOk;
      memE.memtoReg   = ex.strb.memtoReg;
      memE.regWrite   = ex.strb.regWrite & condOk;
      memE.pcWrite    = ex.strb.pcWrite & condOk;
      memE.byteLoad   = ex.strb.byteAccess & ex.strb.memtoReg;
      memE.byteMask   = ex.strb.byteAccess ? (4'b0001 << ex.addrLow) : wordMask;
      memE.byteOffset = ex.addrLow;

      checkEq("srcSelD", 32'(srcSelD), 32'(cur.srcSel));
      checkEq("exCtrlE", 32'(exCtrlE), 32'({ex.aluSrc, ex.aluCtl}));
      checkEq("flagsE", 32'(flagsE), 32'(fwdExp));
      checkEq("branchTakenE", 32'(branchTakenE), 32'(ex.strb.branch & condOk));
      checkEq("memCtrlM", 32'(memCtrlM), 32'(memExp));
      checkEq("wbCtrlW", 32'(wbCtrlW), 32'(wbExp));
      checkEq("flagsReg", 32'(flagsReg), 32'(flagsRegExp));
      checkEq("pcWrPendingF", 32'(pcWrPendingF),
              32'(cur.strb.pcWrite | ex.strb.pcWrite | memExp.pcWrite));

      // Step the model over the rising edge
      if (flagWrW) flagsRegExp = flagsWExp;
      wbExp.memtoReg   = memExp.memtoReg;
      wbExp.regWrite   = memExp.regWrite;
      wbExp.pcWrite    = memExp.pcWrite;
      wbExp.byteLoad   = memExp.byteLoad;
      wbExp.byteOffset = memExp.byteOffset;
      flagWrW   = flagWrM;
      flagsWExp = flagsMExp;
      memExp    = memE;
      flagWrM   = flagWrE;
      flagsMExp = nextFlags;
      if (!cur.stall) begin
        if (cur.flush) ex = '0;  // Bubble
        else ex = cur;
      end

      if (k == rows.size() - 1 || rowTest[k + 1] != rowTest[k]) begin
        $display("Test %s: %s", rowTest[k], (errorCount == groupStart) ? "ok" : "mismatches");
        groupStart = errorCount;
      end
      @(negedge clk);
    end

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // ====================
  // Watchdog
  // ====================
  initial begin
    wait (tableReady);
    #((rows.size() + 8 + 16) * 20);  // Rows plus reset plus margin
    $display("Timeout: the stimulus loop did not complete in time");
    $display("TB FAILED");
    $finish;
  end

endmodule

/* list.f */
src/ctrlPkg.sv
src/mainDecoder.sv
src/condCheck.sv
src/byteLaneMask.sv
src/executeStage.sv
src/retireStage.sv
src/armController.sv
testbench/armController_asserts.sv
testbench/controllerTb.sv

/* Makefile */
TOP = controllerTb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --assert --top-module $(TOP) -f list.f -o simv
	./obj_dir/simv > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
